// File: include/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// datapath and address width
`define CPU_XLEN 32

// architectural registers
`define CPU_REG_COUNT 32
`define CPU_REG_AW 5

// first fetch address out of reset
`define CPU_RESET_PC 32'h1c00_0000

`endif

// File: design/cpu_pkg.sv
`default_nettype none

`include "cpu_params.svh"

package cpu_pkg;

    typedef logic [`CPU_XLEN-1:0] word_t;
    typedef logic [`CPU_REG_AW-1:0] reg_addr_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_LUI
    } alu_op_e;

    typedef enum logic [1:0] {
        MEM_NONE,
        MEM_LOAD,
        MEM_STORE
    } mem_op_e;

    typedef struct packed {
        word_t pc;
        word_t inst;
    } fd_t;

    typedef struct packed {
        word_t     pc;
        alu_op_e   alu_op;
        word_t     src1;
        word_t     src2;
        mem_op_e   mem_op;
        word_t     store_data;
        logic      rf_we;
        reg_addr_t rf_waddr;
    } de_t;

    typedef struct packed {
        word_t     pc;
        word_t     result;
        logic      is_load;
        logic      rf_we;
        reg_addr_t rf_waddr;
    } em_t;

    // writeback, also the shape of every forwarding source
    typedef struct packed {
        word_t     pc;
        logic      rf_we;
        reg_addr_t rf_waddr;
        word_t     rf_wdata;
    } wb_t;

endpackage

`default_nettype wire

// File: design/regfile.sv
`default_nettype none

`include "cpu_params.svh"

module regfile (
    input  logic               clk,
    input  logic               arst_n,
    input  cpu_pkg::reg_addr_t raddr1,
    input  cpu_pkg::reg_addr_t raddr2,
    output cpu_pkg::word_t     rdata1,
    output cpu_pkg::word_t     rdata2,
    input  logic               we,
    input  cpu_pkg::reg_addr_t waddr,
    input  cpu_pkg::word_t     wdata
);
    import cpu_pkg::*;

    word_t regs [`CPU_REG_COUNT];

    // r0 is cleared at reset and never written
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `CPU_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];

endmodule

`default_nettype wire

// File: design/fetch_stage.sv
`default_nettype none

`include "cpu_params.svh"

module fetch_stage (
    input  logic           clk,
    input  logic           arst_n,
    input  logic           stall,
    input  logic           br_cancel,
    input  cpu_pkg::word_t br_target,
    input  cpu_pkg::word_t inst_sram_rdata,
    output logic           inst_sram_en,
    output cpu_pkg::word_t inst_sram_addr,
    output cpu_pkg::fd_t   fd,
    output logic           fd_valid
);
    import cpu_pkg::*;

    // address of the word now returned on inst_sram_rdata
    word_t pc;
    logic  fs_valid;
    word_t next_pc;

    always_comb begin
        if (br_cancel) begin
            next_pc = br_target;
        end else if (stall) begin
            next_pc = pc;
        end else begin
            next_pc = pc + word_t'(4);
        end
    end

    assign inst_sram_en   = 1'b1;
    assign inst_sram_addr = next_pc;

    // pc starts one word early so the first request is the reset pc
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc       <= `CPU_RESET_PC - word_t'(4);
            fs_valid <= 1'b0;
            fd_valid <= 1'b0;
        end else begin
            pc       <= next_pc;
            fs_valid <= 1'b1;
            if (br_cancel) begin
                fd_valid <= 1'b0;
            end else if (!stall) begin
                fd_valid <= fs_valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            fd.pc   <= pc;
            fd.inst <= inst_sram_rdata;
        end
    end

endmodule

`default_nettype wire

// File: design/decode_stage.sv
`default_nettype none

`include "cpu_params.svh"

module decode_stage (
    input  logic               clk,
    input  logic               arst_n,
    input  cpu_pkg::fd_t       fd,
    input  logic               fd_valid,
    output cpu_pkg::reg_addr_t rf_raddr1,
    output cpu_pkg::reg_addr_t rf_raddr2,
    input  cpu_pkg::word_t     rf_rdata1,
    input  cpu_pkg::word_t     rf_rdata2,
    input  cpu_pkg::wb_t       ex_fwd,
    input  cpu_pkg::wb_t       mem_fwd,
    input  cpu_pkg::wb_t       wb_fwd,
    input  logic               ex_fwd_valid,
    input  logic               mem_fwd_valid,
    input  logic               wb_fwd_valid,
    input  logic               ex_is_load,
    output logic               stall,
    output logic               br_cancel,
    output cpu_pkg::word_t     br_target,
    output cpu_pkg::de_t       de,
    output logic               de_valid
);
    import cpu_pkg::*;

    reg_addr_t   rd;
    reg_addr_t   rj;
    reg_addr_t   rk;
    logic [11:0] si12;
    logic [19:0] si20;
    logic [15:0] offs16;
    logic [25:0] offs26;
    logic        is_add, is_sub, is_and, is_or;
    logic        is_addi, is_lu12i, is_ld, is_st;
    logic        is_beq, is_bne, is_b;
    logic        is_3r, uses_r1, uses_r2, writes_rd;
    logic        load_use;
    word_t       v1;
    word_t       v2;
    de_t         de_next;

    function automatic logic fwd_hit(input wb_t src, input logic valid, input reg_addr_t addr);
        return valid && src.rf_we && src.rf_waddr == addr && addr != '0;
    endfunction

    // youngest producer wins
    function automatic word_t fwd_value(input reg_addr_t addr, input word_t rf_value);
        if (fwd_hit(ex_fwd, ex_fwd_valid, addr)) begin
            return ex_fwd.rf_wdata;
        end else if (fwd_hit(mem_fwd, mem_fwd_valid, addr)) begin
            return mem_fwd.rf_wdata;
        end else if (fwd_hit(wb_fwd, wb_fwd_valid, addr)) begin
            return wb_fwd.rf_wdata;
        end
        return rf_value;
    endfunction

    assign rd     = fd.inst[4:0];
    assign rj     = fd.inst[9:5];
    assign rk     = fd.inst[14:10];
    assign si12   = fd.inst[21:10];
    assign si20   = fd.inst[24:5];
    assign offs16 = fd.inst[25:10];
    assign offs26 = {fd.inst[9:0], fd.inst[25:10]};

    assign is_add   = fd.inst[31:15] == 17'h00020;
    assign is_sub   = fd.inst[31:15] == 17'h00022;
    assign is_and   = fd.inst[31:15] == 17'h00029;
    assign is_or    = fd.inst[31:15] == 17'h0002a;
    assign is_addi  = fd.inst[31:22] == 10'h00a;
    assign is_ld    = fd.inst[31:22] == 10'h0a2;
    assign is_st    = fd.inst[31:22] == 10'h0a6;
    assign is_lu12i = fd.inst[31:25] == 7'h0a;
    assign is_beq   = fd.inst[31:26] == 6'h16;
    assign is_bne   = fd.inst[31:26] == 6'h17;
    assign is_b     = fd.inst[31:26] == 6'h14;

    assign is_3r     = is_add || is_sub || is_and || is_or;
    assign uses_r1   = is_3r || is_addi || is_ld || is_st || is_beq || is_bne;
    assign uses_r2   = is_3r || is_st || is_beq || is_bne;
    assign writes_rd = is_3r || is_addi || is_lu12i || is_ld;

    // st.w and the compare branches read rd on the second port
    assign rf_raddr1 = rj;
    assign rf_raddr2 = is_3r ? rk : rd;

    always_comb begin
        v1 = fwd_value(rf_raddr1, rf_rdata1);
        v2 = fwd_value(rf_raddr2, rf_rdata2);
    end

    assign load_use = (uses_r1 && fwd_hit(ex_fwd, ex_fwd_valid && ex_is_load, rf_raddr1))
                   || (uses_r2 && fwd_hit(ex_fwd, ex_fwd_valid && ex_is_load, rf_raddr2));
    assign stall    = fd_valid && load_use;

    assign br_cancel = fd_valid && !stall
                    && (is_b || (is_beq && v1 == v2) || (is_bne && v1 != v2));
    assign br_target = is_b ? fd.pc + {{(`CPU_XLEN-28){offs26[25]}}, offs26, 2'b00}
                            : fd.pc + {{(`CPU_XLEN-18){offs16[15]}}, offs16, 2'b00};

    always_comb begin
        de_next.pc         = fd.pc;
        de_next.alu_op     = ALU_ADD;
        de_next.src1       = v1;
        de_next.src2       = v2;
        de_next.mem_op     = MEM_NONE;
        de_next.store_data = v2;
        de_next.rf_we      = writes_rd && rd != '0;
        de_next.rf_waddr   = rd;
        if (is_sub) begin
            de_next.alu_op = ALU_SUB;
        end else if (is_and) begin
            de_next.alu_op = ALU_AND;
        end else if (is_or) begin
            de_next.alu_op = ALU_OR;
        end else if (is_lu12i) begin
            de_next.alu_op = ALU_LUI;
            de_next.src2   = {si20, 12'b0};
        end
        if (is_addi || is_ld || is_st) begin
            de_next.src2 = {{(`CPU_XLEN-12){si12[11]}}, si12};
        end
        if (is_ld) begin
            de_next.mem_op = MEM_LOAD;
        end else if (is_st) begin
            de_next.mem_op = MEM_STORE;
        end
    end

    // a stall sends a bubble into execute
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            de_valid <= 1'b0;
        end else begin
            de_valid <= fd_valid && !stall;
        end
    end

    always_ff @(posedge clk) begin
        de <= de_next;
    end

endmodule

`default_nettype wire

// File: design/exec_stage.sv
`default_nettype none

module exec_stage (
    input  logic           clk,
    input  logic           arst_n,
    input  cpu_pkg::de_t   de,
    input  logic           de_valid,
    output logic           data_sram_en,
    output logic [3:0]     data_sram_we,
    output cpu_pkg::word_t data_sram_addr,
    output cpu_pkg::word_t data_sram_wdata,
    output cpu_pkg::wb_t   ex_fwd,
    output logic           ex_fwd_valid,
    output logic           ex_is_load,
    output cpu_pkg::em_t   em,
    output logic           em_valid
);
    import cpu_pkg::*;

    word_t result;

    always_comb begin
        case (de.alu_op)
            ALU_SUB: result = de.src1 - de.src2;
            ALU_AND: result = de.src1 & de.src2;
            ALU_OR:  result = de.src1 | de.src2;
            ALU_LUI: result = de.src2;
            default: result = de.src1 + de.src2;
        endcase
    end

    // loads and stores both address the data SRAM from here
    assign data_sram_en    = de_valid && de.mem_op != MEM_NONE;
    assign data_sram_we    = (de_valid && de.mem_op == MEM_STORE) ? 4'hf : 4'h0;
    assign data_sram_addr  = result;
    assign data_sram_wdata = de.store_data;

    // unregistered result, not yet valid for a load
    assign ex_fwd.pc       = de.pc;
    assign ex_fwd.rf_we    = de.rf_we;
    assign ex_fwd.rf_waddr = de.rf_waddr;
    assign ex_fwd.rf_wdata = result;
    assign ex_fwd_valid    = de_valid;
    assign ex_is_load      = de.mem_op == MEM_LOAD;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            em_valid <= 1'b0;
        end else begin
            em_valid <= de_valid;
        end
    end

    always_ff @(posedge clk) begin
        em.pc       <= de.pc;
        em.result   <= result;
        em.is_load  <= de.mem_op == MEM_LOAD;
        em.rf_we    <= de.rf_we;
        em.rf_waddr <= de.rf_waddr;
    end

endmodule

`default_nettype wire

// File: design/mem_wb_stage.sv
`default_nettype none

module mem_wb_stage (
    input  logic               clk,
    input  logic               arst_n,
    input  cpu_pkg::em_t       em,
    input  logic               em_valid,
    input  cpu_pkg::word_t     data_sram_rdata,
    output cpu_pkg::wb_t       mem_fwd,
    output logic               mem_fwd_valid,
    output cpu_pkg::wb_t       wb,
    output logic               wb_valid,
    output cpu_pkg::word_t     debug_wb_pc,
    output logic [3:0]         debug_wb_rf_we,
    output cpu_pkg::reg_addr_t debug_wb_rf_wnum,
    output cpu_pkg::word_t     debug_wb_rf_wdata
);

    // load data arrives one cycle after the execute request
    assign mem_fwd.pc       = em.pc;
    assign mem_fwd.rf_we    = em.rf_we;
    assign mem_fwd.rf_waddr = em.rf_waddr;
    assign mem_fwd.rf_wdata = em.is_load ? data_sram_rdata : em.result;
    assign mem_fwd_valid    = em_valid;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= em_valid;
        end
    end

    always_ff @(posedge clk) begin
        wb <= mem_fwd;
    end

    // trace only for retiring register writes
    assign debug_wb_pc       = wb.pc;
    assign debug_wb_rf_we    = {4{wb_valid && wb.rf_we}};
    assign debug_wb_rf_wnum  = wb.rf_waddr;
    assign debug_wb_rf_wdata = wb.rf_wdata;

endmodule

`default_nettype wire

// File: design/cpu_top.sv
`default_nettype none

module cpu_top (
    input  logic               clk,
    input  logic               arst_n,
    input  cpu_pkg::word_t     inst_sram_rdata,
    output logic               inst_sram_en,
    output cpu_pkg::word_t     inst_sram_addr,
    input  cpu_pkg::word_t     data_sram_rdata,
    output logic               data_sram_en,
    output logic [3:0]         data_sram_we,
    output cpu_pkg::word_t     data_sram_addr,
    output cpu_pkg::word_t     data_sram_wdata,
    output cpu_pkg::word_t     debug_wb_pc,
    output logic [3:0]         debug_wb_rf_we,
    output cpu_pkg::reg_addr_t debug_wb_rf_wnum,
    output cpu_pkg::word_t     debug_wb_rf_wdata
);
    import cpu_pkg::*;

    fd_t       fd;
    logic      fd_valid;
    logic      stall;
    logic      br_cancel;
    word_t     br_target;
    reg_addr_t rf_raddr1;
    reg_addr_t rf_raddr2;
    word_t     rf_rdata1;
    word_t     rf_rdata2;
    de_t       de;
    logic      de_valid;
    wb_t       ex_fwd;
    logic      ex_fwd_valid;
    logic      ex_is_load;
    em_t       em;
    logic      em_valid;
    wb_t       mem_fwd;
    logic      mem_fwd_valid;
    wb_t       wb;
    logic      wb_valid;

    fetch_stage u_fetch (
        .clk, .arst_n, .stall, .br_cancel, .br_target,
        .inst_sram_rdata, .inst_sram_en, .inst_sram_addr,
        .fd, .fd_valid
    );

    decode_stage u_decode (
        .clk, .arst_n, .fd, .fd_valid,
        .rf_raddr1, .rf_raddr2, .rf_rdata1, .rf_rdata2,
        .ex_fwd, .mem_fwd,
        .wb_fwd       (wb),
        .ex_fwd_valid, .mem_fwd_valid,
        .wb_fwd_valid (wb_valid),
        .ex_is_load, .stall, .br_cancel, .br_target,
        .de, .de_valid
    );

    exec_stage u_exec (
        .clk, .arst_n, .de, .de_valid,
        .data_sram_en, .data_sram_we, .data_sram_addr, .data_sram_wdata,
        .ex_fwd, .ex_fwd_valid, .ex_is_load,
        .em, .em_valid
    );

    mem_wb_stage u_mem_wb (
        .clk, .arst_n, .em, .em_valid, .data_sram_rdata,
        .mem_fwd, .mem_fwd_valid, .wb, .wb_valid,
        .debug_wb_pc, .debug_wb_rf_we, .debug_wb_rf_wnum, .debug_wb_rf_wdata
    );

    regfile u_regfile (
        .clk    (clk),
        .arst_n (arst_n),
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .we     (wb_valid && wb.rf_we),
        .waddr  (wb.rf_waddr),
        .wdata  (wb.rf_wdata)
    );

endmodule

`default_nettype wire

// File: tb/sram_model.sv
`default_nettype none

`include "cpu_params.svh"

module sram_model #(
    parameter int prog_len = 22
) (
    input  logic           clk,
    input  logic           arst_n,
    input  cpu_pkg::word_t seed_word,
    input  logic           inst_sram_en,
    input  cpu_pkg::word_t inst_sram_addr,
    output cpu_pkg::word_t inst_sram_rdata,
    input  logic           data_sram_en,
    input  logic [3:0]     data_sram_we,
    input  cpu_pkg::word_t data_sram_addr,
    input  cpu_pkg::word_t data_sram_wdata,
    output cpu_pkg::word_t data_sram_rdata
);
    import cpu_pkg::*;

    // random word lives at byte address 0x40
    localparam int seed_index = 16;

    word_t      rom [prog_len];
    word_t      dmem [256];
    word_t      inst_req = `CPU_RESET_PC;
    logic       data_req_en = 1'b0;
    logic [7:0] data_req_index = '0;
    word_t      inst_q = '0;
    word_t      data_q = '0;

    function automatic word_t enc_3r(input logic [16:0] op, input int rd, input int rj,
                                     input int rk);
        return {op, rk[4:0], rj[4:0], rd[4:0]};
    endfunction

    function automatic word_t enc_ri12(input logic [9:0] op, input int rd, input int rj,
                                       input logic [11:0] si12);
        return {op, si12, rj[4:0], rd[4:0]};
    endfunction

    function automatic word_t enc_lu12i(input int rd, input logic [19:0] si20);
        return {7'h0a, si20, rd[4:0]};
    endfunction

    function automatic word_t enc_br(input logic [5:0] op, input int rj, input int rd,
                                     input logic [15:0] offs);
        return {op, offs, rj[4:0], rd[4:0]};
    endfunction

    function automatic word_t enc_b(input logic [25:0] offs);
        return {6'h14, offs[15:0], offs[25:16]};
    endfunction

    function automatic word_t fill_word(input word_t addr);
        return {addr[15:0], addr[31:16]} ^ addr ^ 32'h6b8d_2f31;
    endfunction

    // past the program end the core spins on a branch to itself
    function automatic word_t fetch_word(input word_t addr);
        int word_index;
        word_index = int'((addr - `CPU_RESET_PC) >> 2);
        if (word_index >= 0 && word_index < prog_len) begin
            return rom[word_index];
        end
        return enc_b(26'd0);
    endfunction

    initial begin
        // dependent ALU chain
        rom[0]  = enc_lu12i(1, 20'h12345);
        rom[1]  = enc_ri12(10'h00a, 1, 1, 12'h678);
        rom[2]  = enc_ri12(10'h00a, 2, 0, 12'h0f0);
        rom[3]  = enc_3r(17'h00020, 3, 1, 2);
        rom[4]  = enc_3r(17'h00022, 4, 3, 1);
        rom[5]  = enc_3r(17'h00029, 5, 4, 3);
        rom[6]  = enc_3r(17'h0002a, 6, 4, 1);
        // r0 as destination, then as source
        rom[7]  = enc_ri12(10'h00a, 0, 1, 12'h005);
        rom[8]  = enc_3r(17'h00020, 7, 0, 6);
        // load-use, then store and reload
        rom[9]  = enc_ri12(10'h0a2, 8, 0, 12'h040);
        rom[10] = enc_ri12(10'h00a, 9, 8, 12'h123);
        rom[11] = enc_ri12(10'h0a6, 9, 0, 12'h080);
        rom[12] = enc_ri12(10'h0a2, 10, 0, 12'h080);
        // beq taken on a just-loaded value
        rom[13] = enc_br(6'h16, 10, 9, 16'd2);
        rom[14] = enc_ri12(10'h00a, 12, 0, 12'h111);
        rom[15] = enc_ri12(10'h00a, 11, 0, 12'hfff);
        rom[16] = enc_br(6'h17, 4, 2, 16'd2);
        rom[17] = enc_ri12(10'h00a, 13, 0, 12'h222);
        rom[18] = enc_b(26'd2);
        rom[19] = enc_ri12(10'h00a, 14, 0, 12'h333);
        rom[20] = enc_ri12(10'h00a, 15, 13, 12'h010);
        rom[21] = enc_b(26'd0);
    end

    // requests taken at the rising edge, data out at the falling edge
    always @(posedge clk) begin
        if (inst_sram_en) begin
            inst_req <= inst_sram_addr;
        end
        data_req_en    <= data_sram_en;
        data_req_index <= data_sram_addr[9:2];
        if (!arst_n) begin
            for (int i = 0; i < 256; i++) begin
                dmem[i] <= fill_word(word_t'(i) << 2);
            end
            dmem[seed_index] <= seed_word;
        end else if (data_sram_en) begin
            for (int b = 0; b < 4; b++) begin
                if (data_sram_we[b]) begin
                    dmem[data_sram_addr[9:2]][8*b +: 8] <= data_sram_wdata[8*b +: 8];
                end
            end
        end
    end

    always @(negedge clk) begin
        inst_q <= fetch_word(inst_req);
        if (data_req_en) begin
            data_q <= dmem[data_req_index];
        end
    end

    assign inst_sram_rdata = inst_q;
    assign data_sram_rdata = data_q;

endmodule

`default_nettype wire

// File: tb/tb_cpu_top.sv
`default_nettype none

`include "cpu_params.svh"

module tb_cpu_top;
    import cpu_pkg::*;

    localparam int prog_len       = 22;
    localparam int reset_cycles   = 10;
    localparam int timeout_cycles = 4 * (prog_len + 10);

    logic       clk = 1'b0;
    logic       arst_n = 1'b0;
    word_t      rand_word = '0;
    word_t      inst_sram_rdata;
    logic       inst_sram_en;
    word_t      inst_sram_addr;
    word_t      data_sram_rdata;
    logic       data_sram_en;
    logic [3:0] data_sram_we;
    word_t      data_sram_addr;
    word_t      data_sram_wdata;
    word_t      debug_wb_pc;
    logic [3:0] debug_wb_rf_we;
    reg_addr_t  debug_wb_rf_wnum;
    word_t      debug_wb_rf_wdata;

    // expected writeback trace in program order
    word_t     exp_pc [$];
    reg_addr_t exp_reg [$];
    word_t     exp_val [$];
    int        trace_idx = 0;
    int        cycles = 0;

    // expected data SRAM requests in program order
    logic [3:0] exp_we [$];
    word_t      exp_addr [$];
    word_t      exp_wdata [$];
    int         req_idx = 0;

    always #10 clk = ~clk;

    cpu_top u_cpu_top (.*);

    sram_model #(.prog_len(prog_len)) u_sram (
        .seed_word (rand_word),
        .*
    );

    task automatic stop_run(input string what);
        $display("%s", what);
        $display("** FAIL **");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic value_error(input string name, input word_t got, input word_t expected);
        stop_run($sformatf("ERROR %s: got 0x%h, expected 0x%h", name, got, expected));
    endtask

    task automatic expect_wb(input int index, input reg_addr_t rd, input word_t value);
        exp_pc.push_back(`CPU_RESET_PC + word_t'(4 * index));
        exp_reg.push_back(rd);
        exp_val.push_back(value);
    endtask

    task automatic expect_req(input logic [3:0] we, input word_t addr, input word_t wdata);
        exp_we.push_back(we);
        exp_addr.push_back(addr);
        exp_wdata.push_back(wdata);
    endtask

    task automatic build_trace();
        word_t r1;
        word_t r2;
        word_t r3;
        word_t r4;
        word_t r6;
        word_t r9;
        r1 = 32'h12345 << 12;
        expect_wb(0, 5'd1, r1);
        r1 = r1 + 32'h678;
        expect_wb(1, 5'd1, r1);
        r2 = 32'h0f0;
        expect_wb(2, 5'd2, r2);
        r3 = r1 + r2;
        expect_wb(3, 5'd3, r3);
        r4 = r3 - r1;
        expect_wb(4, 5'd4, r4);
        expect_wb(5, 5'd5, r4 & r3);
        r6 = r4 | r1;
        expect_wb(6, 5'd6, r6);
        // pc 7 targets r0 and never shows up
        expect_wb(8, 5'd7, 32'h0 + r6);
        expect_wb(9, 5'd8, rand_word);
        r9 = rand_word + 32'h123;
        expect_wb(10, 5'd9, r9);
        expect_wb(12, 5'd10, r9);
        // beq skips pc 14
        expect_wb(15, 5'd11, 32'hffff_ffff);
        expect_wb(17, 5'd13, 32'h222);
        // b skips pc 19
        expect_wb(20, 5'd15, 32'h222 + 32'h10);
    endtask

    // address is r0 plus the immediate, store data is r9
    task automatic build_data_requests();
        word_t r9;
        r9 = rand_word + 32'h123;
        expect_req(4'h0, 32'h40, 32'h0);
        expect_req(4'hf, 32'h80, r9);
        expect_req(4'h0, 32'h80, 32'h0);
    endtask

    task automatic check_data_req();
        if (req_idx >= exp_addr.size()) begin
            stop_run($sformatf("unexpected data SRAM request at address 0x%h", data_sram_addr));
        end else begin
            assert (data_sram_we == exp_we[req_idx])
                else value_error("data_sram_we", word_t'(data_sram_we),
                                 word_t'(exp_we[req_idx]));
            assert (data_sram_addr == exp_addr[req_idx])
                else value_error("data_sram_addr", data_sram_addr, exp_addr[req_idx]);
            if (exp_we[req_idx] != 4'h0) begin
                assert (data_sram_wdata == exp_wdata[req_idx])
                    else value_error("data_sram_wdata", data_sram_wdata, exp_wdata[req_idx]);
            end
            req_idx = req_idx + 1;
        end
    endtask

    initial begin
        rand_word = $urandom(32'h0b29532b);
        build_trace();
        build_data_requests();
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > timeout_cycles) begin
            stop_run($sformatf("timeout: trace not complete after %0d cycles", cycles));
        end
    end

    // checks come before the reset release on the falling edge
    always @(negedge clk) begin
        if (arst_n && data_sram_en) begin
            check_data_req();
        end
        if (!arst_n) begin
            assert (debug_wb_rf_we == 4'h0)
                else value_error("debug_wb_rf_we", word_t'(debug_wb_rf_we), 32'h0);
            assert (data_sram_en == 1'b0)
                else value_error("data_sram_en", word_t'(data_sram_en), 32'h0);
            assert (inst_sram_en == 1'b1)
                else value_error("inst_sram_en", word_t'(inst_sram_en), 32'h1);
            assert (inst_sram_addr == `CPU_RESET_PC)
                else value_error("inst_sram_addr", inst_sram_addr, `CPU_RESET_PC);
            if (cycles >= reset_cycles) begin
                arst_n = 1'b1;
            end
        end else if (debug_wb_rf_we != 4'h0) begin
            assert (debug_wb_rf_we == 4'hf)
                else value_error("debug_wb_rf_we", word_t'(debug_wb_rf_we), 32'hf);
            assert (debug_wb_pc == exp_pc[trace_idx])
                else value_error("debug_wb_pc", debug_wb_pc, exp_pc[trace_idx]);
            assert (debug_wb_rf_wnum == exp_reg[trace_idx])
                else value_error("debug_wb_rf_wnum", word_t'(debug_wb_rf_wnum),
                                 word_t'(exp_reg[trace_idx]));
            assert (debug_wb_rf_wdata == exp_val[trace_idx])
                else value_error("debug_wb_rf_wdata", debug_wb_rf_wdata, exp_val[trace_idx]);
            trace_idx = trace_idx + 1;
            if (trace_idx == exp_pc.size()) begin
                $display("** PASS **");
                $finish;
            end
        end
    end

endmodule

`default_nettype wire

// File: build.f
+incdir+include
design/cpu_pkg.sv
design/regfile.sv
design/fetch_stage.sv
design/decode_stage.sv
design/exec_stage.sv
design/mem_wb_stage.sv
design/cpu_top.sv
tb/sram_model.sv
tb/tb_cpu_top.sv

// File: Makefile
SIM = obj_dir/Vtb_cpu_top

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f build.f --top-module tb_cpu_top -Mdir obj_dir

run: build
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '** PASS **'

lint:
	verilator --lint-only --timing -f build.f --top-module cpu_top

clean:
	rm -rf obj_dir
